// File: fpu_32.f
+incdir+hdl
hdl/fpu_pkg.sv
hdl/fpu_decoder.sv
hdl/fp32_add_sub.sv
hdl/fp32_mul.sv
hdl/fp32_srt_div.sv
hdl/fpu_issue_ctrl.sv
hdl/fpu_32.sv
verif/fpu_32_chk.sv
verif/fpu_32_tb.sv

// File: hdl/fp32_add_sub.sv
`timescale 1ns/10ps
`include "fpu_settings.svh"

module fp32_add_sub
    import fpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  logic    subtract,
    input  fp32_t   a,
    input  fp32_t   b,
    output logic    done,
    output fp32_t   result,
    output fflags_t flags
);

    logic              sb_eff;
    logic              a_nan, b_nan, a_inf, b_inf;
    logic              swap;
    logic [7:0]        ex_c, ey_c, diff;
    logic [26:0]       ma_c, mb_c, my_raw;
    logic [53:0]       shifted;
    logic              sp_c;
    fp32_t             sp_res_c;
    fflags_t           sp_flags_c;

    logic              v1;
    logic              sx, x_sub, sp;
    logic [7:0]        ex;
    logic [26:0]       mx, my;
    fp32_t             sp_res;
    fflags_t           sp_flags;

    logic [27:0]       sum;
    logic [26:0]       norm;
    logic [4:0]        lz;
    logic signed [9:0] exp_n, exp_f;
    logic              rnd_up, inexact;
    logic [24:0]       mant_r;
    fp32_t             res_c;
    fflags_t           flags_c;

    assign sb_eff = b[31] ^ subtract;
    assign a_nan  = (a[30:23] == 8'hff) && (a[22:0] != '0);
    assign b_nan  = (b[30:23] == 8'hff) && (b[22:0] != '0);
    assign a_inf  = (a[30:23] == 8'hff) && (a[22:0] == '0);
    assign b_inf  = (b[30:23] == 8'hff) && (b[22:0] == '0);

    // subnormals flush to zero, three extra bits for guard, round, sticky
    assign ma_c = (a[30:23] == 8'h00) ? '0 : {1'b1, a[22:0], 3'b000};
    assign mb_c = (b[30:23] == 8'h00) ? '0 : {1'b1, b[22:0], 3'b000};

    // larger magnitude goes first
    assign swap    = (b[30:0] > a[30:0]);
    assign ex_c    = swap ? b[30:23] : a[30:23];
    assign ey_c    = swap ? a[30:23] : b[30:23];
    assign my_raw  = swap ? ma_c : mb_c;
    assign diff    = ex_c - ey_c;
    assign shifted = {my_raw, 27'd0} >> ((diff > 8'd27) ? 8'd27 : diff);

    always_comb begin
        sp_c       = 1'b1;
        sp_res_c   = `CANON_NAN;
        sp_flags_c = '0;
        if (a_nan || b_nan || (a_inf && b_inf && (a[31] != sb_eff))) begin
            sp_flags_c = 5'b10000;
        end else if (a_inf) begin
            sp_res_c = a;
        end else if (b_inf) begin
            sp_res_c = {sb_eff, b[30:0]};
        end else begin
            sp_c = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            v1   <= 1'b0;
            done <= 1'b0;
        end else begin
            v1   <= start;
            done <= v1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sx       <= swap ? sb_eff : a[31];
            x_sub    <= a[31] ^ sb_eff;
            ex       <= ex_c;
            mx       <= swap ? mb_c : ma_c;
            my       <= {shifted[53:28], shifted[27] | (|shifted[26:0])};
            sp       <= sp_c;
            sp_res   <= sp_res_c;
            sp_flags <= sp_flags_c;
        end
    end

    // stage two, add and normalize
    always_comb begin
        sum = x_sub ? ({1'b0, mx} - {1'b0, my}) : ({1'b0, mx} + {1'b0, my});
        lz  = '0;
        for (int i = 0; i < 27; i++) begin
            if (sum[i]) begin
                lz = 5'(26 - i);
            end
        end
        if (sum[27]) begin
            norm  = {sum[27:2], sum[1] | sum[0]};
            exp_n = $signed({2'b00, ex}) + 10'sd1;
        end else begin
            norm  = sum[26:0] << lz;
            exp_n = $signed({2'b00, ex}) - $signed({5'd0, lz});
        end
        inexact = |norm[2:0];
        rnd_up  = norm[2] & (norm[1] | norm[0] | norm[3]);
        mant_r  = {1'b0, norm[26:3]} + 25'(rnd_up);
        exp_f   = mant_r[24] ? exp_n + 10'sd1 : exp_n;

        flags_c = '0;
        if (sp) begin
            res_c   = sp_res;
            flags_c = sp_flags;
        end else if (sum == '0) begin
            // exact cancellation gives +0
            res_c = {sx & ~x_sub, 31'd0};
        end else if (exp_f >= 10'sd255) begin
            res_c   = {sx, 8'hff, 23'd0};
            flags_c = 5'b00101;
        end else if (exp_f <= 10'sd0) begin
            res_c   = {sx, 31'd0};
            flags_c = 5'b00011;
        end else begin
            res_c   = {sx, exp_f[7:0], mant_r[22:0]};
            flags_c = {4'b0000, inexact};
        end
    end

    always_ff @(posedge clk) begin
        if (v1) begin
            result <= res_c;
            flags  <= flags_c;
        end
    end

endmodule

// File: hdl/fp32_mul.sv
`timescale 1ns/10ps
`include "fpu_settings.svh"

module fp32_mul
    import fpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  fp32_t   a,
    input  fp32_t   b,
    output logic    done,
    output fp32_t   result,
    output fflags_t flags
);

    logic              a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
    logic              sp_c, sgn_c;
    fp32_t             sp_res_c;
    fflags_t           sp_flags_c;

    logic              v1, sgn, sp;
    logic signed [9:0] e;
    logic [47:0]       p;
    fp32_t             sp_res;
    fflags_t           sp_flags;

    logic [23:0]       mant;
    logic              grd, stk, rnd_up;
    logic [24:0]       mant_r;
    logic signed [9:0] exp_n, exp_f;
    fp32_t             res_c;
    fflags_t           flags_c;

    // exponent zero counts as zero, subnormals included
    assign a_zero = (a[30:23] == 8'h00);
    assign b_zero = (b[30:23] == 8'h00);
    assign a_inf  = (a[30:23] == 8'hff) && (a[22:0] == '0);
    assign b_inf  = (b[30:23] == 8'hff) && (b[22:0] == '0);
    assign a_nan  = (a[30:23] == 8'hff) && (a[22:0] != '0);
    assign b_nan  = (b[30:23] == 8'hff) && (b[22:0] != '0);
    assign sgn_c  = a[31] ^ b[31];

    always_comb begin
        sp_c       = 1'b1;
        sp_res_c   = `CANON_NAN;
        sp_flags_c = '0;
        if (a_nan || b_nan || (a_zero && b_inf) || (a_inf && b_zero)) begin
            sp_flags_c = 5'b10000;
        end else if (a_inf || b_inf) begin
            sp_res_c = {sgn_c, 8'hff, 23'd0};
        end else if (a_zero || b_zero) begin
            sp_res_c = {sgn_c, 31'd0};
        end else begin
            sp_c = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            v1   <= 1'b0;
            done <= 1'b0;
        end else begin
            v1   <= start;
            done <= v1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sgn      <= sgn_c;
            e        <= $signed({2'b00, a[30:23]}) + $signed({2'b00, b[30:23]}) - 10'sd127;
            p        <= {1'b1, a[22:0]} * {1'b1, b[22:0]};
            sp       <= sp_c;
            sp_res   <= sp_res_c;
            sp_flags <= sp_flags_c;
        end
    end

    // product lies in [1,4), at most one shift right
    always_comb begin
        if (p[47]) begin
            mant  = p[47:24];
            grd   = p[23];
            stk   = |p[22:0];
            exp_n = e + 10'sd1;
        end else begin
            mant  = p[46:23];
            grd   = p[22];
            stk   = |p[21:0];
            exp_n = e;
        end
        rnd_up = grd & (stk | mant[0]);
        mant_r = {1'b0, mant} + 25'(rnd_up);
        exp_f  = mant_r[24] ? exp_n + 10'sd1 : exp_n;

        if (sp) begin
            res_c   = sp_res;
            flags_c = sp_flags;
        end else if (exp_f >= 10'sd255) begin
            res_c   = {sgn, 8'hff, 23'd0};
            flags_c = 5'b00101;
        end else if (exp_f <= 10'sd0) begin
            res_c   = {sgn, 31'd0};
            flags_c = 5'b00011;
        end else begin
            res_c   = {sgn, exp_f[7:0], mant_r[22:0]};
            flags_c = {4'b0000, grd | stk};
        end
    end

    always_ff @(posedge clk) begin
        if (v1) begin
            result <= res_c;
            flags  <= flags_c;
        end
    end

endmodule

// File: hdl/fp32_srt_div.sv
`timescale 1ns/10ps
`include "fpu_settings.svh"

module fp32_srt_div
    import fpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  fp32_t   a,
    input  fp32_t   b,
    output logic    done,
    output fp32_t   result,
    output fflags_t flags
);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_ITER,
        DIV_ROUND
    } div_state_t;

    div_state_t         state;
    logic [4:0]         iter;
    logic               load;
    logic               a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
    logic               sp_c, sgn_c, sgn;
    fp32_t              sp_res_c;
    fflags_t            sp_flags_c;

    // remainder and divisor, 1.0 is 2^25
    logic signed [28:0] w, w2, w_next, d;
    logic [4:0]         top;
    logic               q_pos, q_neg;
    logic [25:0]        qp, qn, q_int;
    logic signed [9:0]  e_q, exp_n, exp_f;
    logic [23:0]        mant;
    logic               grd, stk, rnd_up;
    logic [24:0]        mant_r;
    fp32_t              res_c;
    fflags_t            flags_c;

    assign load   = (state == DIV_IDLE) && start;
    assign a_zero = (a[30:23] == 8'h00);
    assign b_zero = (b[30:23] == 8'h00);
    assign a_inf  = (a[30:23] == 8'hff) && (a[22:0] == '0);
    assign b_inf  = (b[30:23] == 8'hff) && (b[22:0] == '0);
    assign a_nan  = (a[30:23] == 8'hff) && (a[22:0] != '0);
    assign b_nan  = (b[30:23] == 8'hff) && (b[22:0] != '0);
    assign sgn_c  = a[31] ^ b[31];

    always_comb begin
        sp_c       = 1'b1;
        sp_res_c   = `CANON_NAN;
        sp_flags_c = '0;
        if (a_nan || b_nan || (a_zero && b_zero) || (a_inf && b_inf)) begin
            sp_flags_c = 5'b10000;
        end else if (a_inf || b_zero) begin
            sp_res_c   = {sgn_c, 8'hff, 23'd0};
            sp_flags_c = a_inf ? 5'b00000 : 5'b01000;
        end else if (a_zero || b_inf) begin
            sp_res_c = {sgn_c, 31'd0};
        end else begin
            sp_c = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= DIV_IDLE;
            iter  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                DIV_IDLE: begin
                    iter <= '0;
                    if (start && sp_c) begin
                        done <= 1'b1;
                    end else if (start) begin
                        state <= DIV_ITER;
                    end
                end
                DIV_ITER: begin
                    iter <= iter + 5'd1;
                    if (iter == 5'(`DIV_ITERS - 1)) begin
                        state <= DIV_ROUND;
                    end
                end
                DIV_ROUND: begin
                    done  <= 1'b1;
                    state <= DIV_IDLE;
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    // digit choice from the top bits of 2w against +-1/2
    assign w2     = w <<< 1;
    assign top    = w2[28:24];
    assign q_pos  = !top[4] && (top != 5'b00000);
    assign q_neg  = top[4] && (top != 5'b11111);
    assign w_next = q_pos ? (w2 - d) : (q_neg ? (w2 + d) : w2);

    always_ff @(posedge clk) begin
        if (load) begin
            w   <= $signed({5'd0, 1'b1, a[22:0]});
            d   <= $signed({4'd0, 1'b1, b[22:0], 1'b0});
            qp  <= '0;
            qn  <= '0;
            sgn <= sgn_c;
            e_q <= $signed({2'b00, a[30:23]}) - $signed({2'b00, b[30:23]}) + 10'sd127;
        end else if (state == DIV_ITER) begin
            w  <= w_next;
            qp <= {qp[24:0], q_pos};
            qn <= {qn[24:0], q_neg};
        end
    end

    // negative remainder means one ulp too many
    always_comb begin
        q_int = qp - qn - 26'(w[28]);
        if (q_int[25]) begin
            mant  = q_int[25:2];
            grd   = q_int[1];
            stk   = q_int[0] | (w != '0);
            exp_n = e_q;
        end else begin
            mant  = q_int[24:1];
            grd   = q_int[0];
            stk   = (w != '0);
            exp_n = e_q - 10'sd1;
        end
        rnd_up = grd & (stk | mant[0]);
        mant_r = {1'b0, mant} + 25'(rnd_up);
        exp_f  = mant_r[24] ? exp_n + 10'sd1 : exp_n;

        if (exp_f >= 10'sd255) begin
            res_c   = {sgn, 8'hff, 23'd0};
            flags_c = 5'b00101;
        end else if (exp_f <= 10'sd0) begin
            res_c   = {sgn, 31'd0};
            flags_c = 5'b00011;
        end else begin
            res_c   = {sgn, exp_f[7:0], mant_r[22:0]};
            flags_c = {4'b0000, grd | stk};
        end
    end

    always_ff @(posedge clk) begin
        if (load && sp_c) begin
            result <= sp_res_c;
            flags  <= sp_flags_c;
        end else if (state == DIV_ROUND) begin
            result <= res_c;
            flags  <= flags_c;
        end
    end

endmodule

// File: hdl/fpu_32.sv
`timescale 1ns/10ps

module fpu_32
    import fpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    cmd_valid,
    input  opcode_t op_code,
    input  funct7_t func_code,
    input  fp32_t   a,
    input  fp32_t   b,
    output logic    cmd_credit,
    output logic    res_valid,
    output fp32_t   result,
    output fflags_t fflags,
    input  logic    res_credit
);

    fpu_mode_t mode;
    logic      illegal;
    logic      add_start, mul_start, div_start, subtract;
    logic      add_done, mul_done, div_done;
    fp32_t     op_a, op_b;
    fp32_t     add_result, mul_result, div_result;
    fflags_t   add_flags, mul_flags, div_flags;

    fpu_decoder decoder_i (
        .op_code   (op_code),
        .func_code (func_code),
        .mode      (mode),
        .illegal   (illegal)
    );

    fpu_issue_ctrl ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .mode       (mode),
        .illegal    (illegal),
        .a          (a),
        .b          (b),
        .cmd_credit (cmd_credit),
        .res_credit (res_credit),
        .res_valid  (res_valid),
        .result     (result),
        .fflags     (fflags),
        .add_start  (add_start),
        .mul_start  (mul_start),
        .div_start  (div_start),
        .subtract   (subtract),
        .op_a       (op_a),
        .op_b       (op_b),
        .add_done   (add_done),
        .mul_done   (mul_done),
        .div_done   (div_done),
        .add_result (add_result),
        .mul_result (mul_result),
        .div_result (div_result),
        .add_flags  (add_flags),
        .mul_flags  (mul_flags),
        .div_flags  (div_flags)
    );

    fp32_add_sub add_i (
        .clk      (clk),
        .rst      (rst),
        .start    (add_start),
        .subtract (subtract),
        .a        (op_a),
        .b        (op_b),
        .done     (add_done),
        .result   (add_result),
        .flags    (add_flags)
    );

    fp32_mul mul_i (
        .clk    (clk),
        .rst    (rst),
        .start  (mul_start),
        .a      (op_a),
        .b      (op_b),
        .done   (mul_done),
        .result (mul_result),
        .flags  (mul_flags)
    );

    fp32_srt_div div_i (
        .clk    (clk),
        .rst    (rst),
        .start  (div_start),
        .a      (op_a),
        .b      (op_b),
        .done   (div_done),
        .result (div_result),
        .flags  (div_flags)
    );

endmodule

// File: hdl/fpu_decoder.sv
`timescale 1ns/10ps
`include "fpu_settings.svh"

module fpu_decoder
    import fpu_pkg::*;
(
    input  opcode_t   op_code,
    input  funct7_t   func_code,
    output fpu_mode_t mode,
    output logic      illegal
);

    always_comb begin
        mode = `MODE_ILL;
        if (op_code == `FP_OPCODE) begin
            case (func_code)
                `F7_ADD: mode = `MODE_ADD;
                `F7_SUB: mode = `MODE_SUB;
                `F7_MUL: mode = `MODE_MUL;
                `F7_DIV: mode = `MODE_DIV;
                default: mode = `MODE_ILL;
            endcase
        end
    end

    // wrong opcode or unknown funct7 both land here
    assign illegal = (mode == `MODE_ILL);

endmodule

// File: hdl/fpu_issue_ctrl.sv
`timescale 1ns/10ps
`include "fpu_settings.svh"

module fpu_issue_ctrl
    import fpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cmd_valid,
    input  fpu_mode_t mode,
    input  logic      illegal,
    input  fp32_t     a,
    input  fp32_t     b,
    output logic      cmd_credit,
    input  logic      res_credit,
    output logic      res_valid,
    output fp32_t     result,
    output fflags_t   fflags,
    output logic      add_start,
    output logic      mul_start,
    output logic      div_start,
    output logic      subtract,
    output fp32_t     op_a,
    output fp32_t     op_b,
    input  logic      add_done,
    input  logic      mul_done,
    input  logic      div_done,
    input  fp32_t     add_result,
    input  fp32_t     mul_result,
    input  fp32_t     div_result,
    input  fflags_t   add_flags,
    input  fflags_t   mul_flags,
    input  fflags_t   div_flags
);

    ctrl_state_t state;
    credit_cnt_t res_cnt;
    fpu_mode_t   mode_r;
    logic        accept, launch;
    logic        sel_done;
    fp32_t       sel_result, hold_result;
    fflags_t     sel_flags, hold_flags;

    // launch marks the cycle after acceptance, operands already held
    assign accept    = (state == IDLE) && cmd_valid && !launch;
    assign add_start = launch && ((mode_r == `MODE_ADD) || (mode_r == `MODE_SUB));
    assign mul_start = launch && (mode_r == `MODE_MUL);
    assign div_start = launch && (mode_r == `MODE_DIV);
    assign subtract  = (mode_r == `MODE_SUB);

    // the slot frees in the same cycle the result leaves
    assign res_valid  = (state == HOLD) && (res_cnt != '0);
    assign cmd_credit = res_valid;
    assign result     = hold_result;
    assign fflags     = hold_flags;

    always_comb begin
        case (mode_r)
            `MODE_MUL: begin
                sel_done   = mul_done;
                sel_result = mul_result;
                sel_flags  = mul_flags;
            end
            `MODE_DIV: begin
                sel_done   = div_done;
                sel_result = div_result;
                sel_flags  = div_flags;
            end
            default: begin
                sel_done   = add_done;
                sel_result = add_result;
                sel_flags  = add_flags;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= IDLE;
            launch  <= 1'b0;
            res_cnt <= credit_cnt_t'(`RES_CREDITS);
        end else begin
            launch  <= accept && !illegal;
            res_cnt <= res_cnt - credit_cnt_t'(res_valid) + credit_cnt_t'(res_credit);
            case (state)
                IDLE: begin
                    if (accept && illegal) begin
                        state <= HOLD;
                    end else if (launch) begin
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    if (sel_done) begin
                        state <= HOLD;
                    end
                end
                HOLD: begin
                    if (res_valid) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_a   <= a;
            op_b   <= b;
            mode_r <= mode;
        end
        // illegal commands get zero with invalid only
        if (accept && illegal) begin
            hold_result <= '0;
            hold_flags  <= 5'b10000;
        end else if ((state == BUSY) && sel_done) begin
            hold_result <= sel_result;
            hold_flags  <= sel_flags;
        end
    end

endmodule

// File: hdl/fpu_pkg.sv
package fpu_pkg;

    // ieee single-precision word
    typedef logic [31:0] fp32_t;

    // nv, dz, of, uf, nx from msb down
    typedef logic [4:0] fflags_t;

    typedef logic [6:0] opcode_t;
    typedef logic [6:0] funct7_t;

    // internal operation selector
    typedef logic [2:0] fpu_mode_t;

    // wide enough for the deeper credit pool
    typedef logic [3:0] credit_cnt_t;

    // command slot states
    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        HOLD
    } ctrl_state_t;

endpackage

// File: hdl/fpu_settings.svh
`ifndef FPU_SETTINGS_SVH
`define FPU_SETTINGS_SVH

// risc-v op-fp major opcode and funct7 codes
`define FP_OPCODE   7'b1010011
`define F7_ADD      7'b0000000
`define F7_SUB      7'b0000100
`define F7_MUL      7'b0001000
`define F7_DIV      7'b0001100

// internal mode codes
`define MODE_MUL    3'b000
`define MODE_ADD    3'b001
`define MODE_SUB    3'b010
`define MODE_DIV    3'b011
`define MODE_ILL    3'b111

`define CMD_CREDITS 1
`define RES_CREDITS 4
`define DIV_ITERS   26
`define CANON_NAN   32'h7fc00000

`endif

// File: run_sim.sh
#!/bin/sh
# build the fpu_32 testbench with Verilator, run it and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fpu_32_tb -f fpu_32.f \
    && ./obj_dir/Vfpu_32_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

// File: verif/fpu_32_chk.sv
`timescale 1ns/10ps
`include "fpu_settings.svh"

module fpu_32_chk
    import fpu_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input ctrl_state_t state,
    input logic        cmd_valid,
    input logic        cmd_credit,
    input logic        res_valid,
    input logic        res_credit,
    input logic        add_start,
    input logic        mul_start,
    input logic        div_start
);

    int credits;
    int cmds_out;

    // result credits and commands in flight, seen from outside the control
    always_ff @(posedge clk) begin
        if (!rst) begin
            credits  <= `RES_CREDITS;
            cmds_out <= 0;
        end else begin
            credits  <= credits - int'(res_valid) + int'(res_credit);
            cmds_out <= cmds_out + int'(cmd_valid) - int'(cmd_credit);
        end
    end

    // a result leaves only against a held credit
    res_needs_credit: assert property (@(posedge clk) disable iff (!rst)
        res_valid |-> (credits != 0))
        else $error("res_valid while the result-credit count is zero");

    // a credit goes back only for a command still in flight
    cmd_credit_with_result: assert property (@(posedge clk) disable iff (!rst)
        cmd_credit |-> (res_valid && (cmds_out != 0)))
        else $error("cmd_credit pulsed without res_valid or without a command in flight");

    idle_after_reset: assert property (@(posedge clk)
        !rst |=> (state == IDLE))
        else $error("control not in IDLE after reset");

    // one operation at a time
    no_start_when_busy: assert property (@(posedge clk) disable iff (!rst)
        (state != IDLE) |-> !(add_start || mul_start || div_start))
        else $error("unit start pulse while BUSY or HOLD");

endmodule

// File: verif/fpu_32_tb.sv
`timescale 1ns/10ps
`include "fpu_settings.svh"

module fpu_32_tb
    import fpu_pkg::*;
();

    localparam int      NUM_ROWS       = 20;
    localparam int      TIMEOUT_CYCLES = NUM_ROWS * (`DIV_ITERS + 2 + 16 + 4) + 100;
    localparam opcode_t FP_OP          = `FP_OPCODE;
    localparam opcode_t BAD_OP         = 7'b0110011;
    localparam funct7_t BAD_F7         = 7'b0000001;

    logic    clk;
    logic    rst;
    logic    cmd_valid;
    opcode_t op_code;
    funct7_t func_code;
    fp32_t   a;
    fp32_t   b;
    logic    cmd_credit;
    logic    res_valid;
    fp32_t   result;
    fflags_t fflags;
    logic    res_credit;

    // one entry per row, expected values are ieee rne with flush to zero
    string   row_name  [NUM_ROWS];
    opcode_t row_op    [NUM_ROWS];
    funct7_t row_f7    [NUM_ROWS];
    fp32_t   row_a     [NUM_ROWS];
    fp32_t   row_b     [NUM_ROWS];
    fp32_t   row_res   [NUM_ROWS];
    fflags_t row_flags [NUM_ROWS];
    int      n_rows;

    logic [31:0] lfsr;
    int          cycle;
    int          tx_idx;
    int          rx_idx;
    int          cmd_cnt;
    int          res_cnt;
    int          val_errs;
    int          proto_errs;
    int          delay;
    int          due;
    int          return_q [$];
    logic        finished;
    logic        timed_out;

    fpu_32 dut_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .op_code    (op_code),
        .func_code  (func_code),
        .a          (a),
        .b          (b),
        .cmd_credit (cmd_credit),
        .res_valid  (res_valid),
        .result     (result),
        .fflags     (fflags),
        .res_credit (res_credit)
    );

    bind fpu_issue_ctrl fpu_32_chk chk_i (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .cmd_valid  (cmd_valid),
        .cmd_credit (cmd_credit),
        .res_valid  (res_valid),
        .res_credit (res_credit),
        .add_start  (add_start),
        .mul_start  (mul_start),
        .div_start  (div_start)
    );

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // four lfsr bits make a delay of 0 to 15 cycles
    task automatic draw_delay(output int d);
        d = 0;
        for (int k = 0; k < 4; k++) begin
            d    = (d << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic add_row(input string name, input opcode_t op, input funct7_t f7,
                           input fp32_t opa, input fp32_t opb,
                           input fp32_t res, input fflags_t flg);
        row_name[n_rows]  = name;
        row_op[n_rows]    = op;
        row_f7[n_rows]    = f7;
        row_a[n_rows]     = opa;
        row_b[n_rows]     = opb;
        row_res[n_rows]   = res;
        row_flags[n_rows] = flg;
        n_rows++;
    endtask

    task automatic check_fp32(input string name, input fp32_t expected, input fp32_t actual);
        if (actual !== expected) begin
            val_errs++;
            $display("ERR %s result expected %08h actual %08h", name, expected, actual);
        end
    endtask

    task automatic check_fflags(input string name, input fflags_t expected,
                                input fflags_t actual);
        if (actual !== expected) begin
            val_errs++;
            $display("ERR %s fflags expected %05b actual %05b", name, expected, actual);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst        = 1'b0;
        cmd_valid  = 1'b0;
        op_code    = '0;
        func_code  = '0;
        a          = '0;
        b          = '0;
        res_credit = 1'b0;
        lfsr       = 32'h201f_3c18;
        n_rows     = 0;
        cycle      = 0;
        tx_idx     = 0;
        rx_idx     = 0;
        cmd_cnt    = `CMD_CREDITS;
        res_cnt    = `RES_CREDITS;
        val_errs   = 0;
        proto_errs = 0;
        finished   = 1'b0;
        timed_out  = 1'b0;

        // flags nibble order nv dz of uf nx
        add_row("add_exact", FP_OP, `F7_ADD, 32'h3f800000, 32'h40000000, 32'h40400000, 5'h00);
        add_row("sub_exact", FP_OP, `F7_SUB, 32'h40a00000, 32'h40400000, 32'h40000000, 5'h00);
        add_row("add_cancel", FP_OP, `F7_ADD, 32'hc0200000, 32'h40200000, 32'h00000000, 5'h00);
        add_row("add_tie_even", FP_OP, `F7_ADD, 32'h3f800000, 32'h33800000, 32'h3f800000, 5'h01);
        add_row("add_tie_up", FP_OP, `F7_ADD, 32'h3f800001, 32'h33800000, 32'h3f800002, 5'h01);
        add_row("add_ovf", FP_OP, `F7_ADD, 32'h7f7fffff, 32'h7f7fffff, 32'h7f800000, 5'h05);
        add_row("mul_exact", FP_OP, `F7_MUL, 32'h3fc00000, 32'h40000000, 32'h40400000, 5'h00);
        add_row("mul_neg", FP_OP, `F7_MUL, 32'hc0400000, 32'h40800000, 32'hc1400000, 5'h00);
        add_row("mul_inexact", FP_OP, `F7_MUL, 32'h3f800001, 32'h3f800001, 32'h3f800002, 5'h01);
        add_row("mul_max_mant", FP_OP, `F7_MUL, 32'h3fffffff, 32'h3fffffff, 32'h407ffffe, 5'h01);
        add_row("mul_uflow", FP_OP, `F7_MUL, 32'h0d800000, 32'h0d800000, 32'h00000000, 5'h03);
        add_row("mul_0_inf", FP_OP, `F7_MUL, 32'h00000000, 32'h7f800000, 32'h7fc00000, 5'h10);
        add_row("div_exact", FP_OP, `F7_DIV, 32'h40c00000, 32'h40000000, 32'h40400000, 5'h00);
        add_row("div_neg", FP_OP, `F7_DIV, 32'hc0f00000, 32'h40200000, 32'hc0400000, 5'h00);
        add_row("div_third", FP_OP, `F7_DIV, 32'h3f800000, 32'h40400000, 32'h3eaaaaab, 5'h01);
        add_row("div_tenth", FP_OP, `F7_DIV, 32'h3f800000, 32'h41200000, 32'h3dcccccd, 5'h01);
        add_row("div_by_zero", FP_OP, `F7_DIV, 32'h40400000, 32'h80000000, 32'hff800000, 5'h08);
        add_row("div_0_0", FP_OP, `F7_DIV, 32'h00000000, 32'h00000000, 32'h7fc00000, 5'h10);
        add_row("bad_opcode", BAD_OP, `F7_ADD, 32'h3f800000, 32'h3f800000, 32'h00000000, 5'h10);
        add_row("bad_funct7", FP_OP, BAD_F7, 32'h40000000, 32'h40000000, 32'h00000000, 5'h10);

        repeat (10) @(posedge clk);
        rst <= 1'b1;
        while (!finished && !timed_out) begin
            @(posedge clk);
        end
        if (timed_out) begin
            proto_errs++;
            $display("run timed out after %0d cycles with %0d of %0d results received",
                     TIMEOUT_CYCLES, rx_idx, n_rows);
        end
        $display("error count: %0d result mismatches, %0d protocol errors",
                 val_errs, proto_errs);
        if (val_errs + proto_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // sender, consumer and credit bookkeeping, all on the rising edge
    always @(posedge clk) begin
        if (rst && !finished && !timed_out) begin
            cycle = cycle + 1;
            if (cycle >= TIMEOUT_CYCLES) begin
                timed_out = 1'b1;
            end

            if (res_valid) begin
                if (res_cnt == 0) begin
                    proto_errs++;
                    $display("result %0d was emitted while no result credit was held", rx_idx);
                end
                if (rx_idx < n_rows) begin
                    check_fp32(row_name[rx_idx], row_res[rx_idx], result);
                    check_fflags(row_name[rx_idx], row_flags[rx_idx], fflags);
                end else begin
                    proto_errs++;
                    $display("a result arrived after the last table row");
                end
                rx_idx++;
                // returns stay in order, one pulse per cycle
                draw_delay(delay);
                due = cycle + delay;
                if (return_q.size() > 0 && due <= return_q[$]) begin
                    due = return_q[$] + 1;
                end
                return_q.push_back(due);
            end
            if (cmd_credit && !res_valid) begin
                proto_errs++;
                $display("a command credit came back without a result");
            end
            res_cnt = res_cnt - int'(res_valid) + int'(res_credit);

            res_credit <= 1'b0;
            if (return_q.size() > 0 && return_q[0] <= cycle) begin
                res_credit <= 1'b1;
                void'(return_q.pop_front());
            end

            if (cmd_credit) begin
                cmd_cnt++;
            end
            if (cmd_cnt > `CMD_CREDITS) begin
                proto_errs++;
                $display("the sender was handed more command credits than it started with");
            end
            cmd_valid <= 1'b0;
            if (cmd_cnt > 0 && tx_idx < n_rows) begin
                cmd_valid <= 1'b1;
                op_code   <= row_op[tx_idx];
                func_code <= row_f7[tx_idx];
                a         <= row_a[tx_idx];
                b         <= row_b[tx_idx];
                cmd_cnt--;
                tx_idx++;
            end

            if (rx_idx >= n_rows && return_q.size() == 0) begin
                finished = 1'b1;
            end
        end
    end

endmodule
